// File: logic/amo_defines.svh
// Sizing macros shared by the AMO memory subsystem
// Include in any file that needs address, FIFO or SRAM dimensions

`ifndef AMO_DEFINES_SVH
`define AMO_DEFINES_SVH

// ----------------------------------------------------------------------
// Address map
// ----------------------------------------------------------------------

// Byte address, bits [2:0] pick a byte within the 64-bit word
`define AMO_ADDR_WIDTH 11

// ----------------------------------------------------------------------
// Storage sizes
// ----------------------------------------------------------------------

`define AMO_FIFO_DEPTH 4   // Request entries, 2, 4 or 8
`define AMO_SRAM_WORDS 256 // 64-bit words, 2**(AMO_ADDR_WIDTH-3)

`endif

// File: logic/amo_pkg.sv
// Types shared by the AMO memory subsystem
// Referenced by scoped name from the FIFO, shim, ALU and top level

package amo_pkg;

    // ------------------------------------------------------------------
    // Atomic opcodes
    // ------------------------------------------------------------------

    // Encoding follows the core's AMO field, None marks a plain access
    typedef enum logic [3:0] {
        AmoNone = 4'h0,
        AmoSwap = 4'h1,
        AmoAdd  = 4'h2,
        AmoAnd  = 4'h3,
        AmoOr   = 4'h4,
        AmoXor  = 4'h5,
        AmoMax  = 4'h6,  // Signed
        AmoMaxu = 4'h7,  // Unsigned
        AmoMin  = 4'h8,  // Signed
        AmoMinu = 4'h9,  // Unsigned
        AmoCas  = 4'hA   // Compare in lower wdata half, swap in upper
    } amo_op_e;

    // ------------------------------------------------------------------
    // Shim sequencer
    // ------------------------------------------------------------------

    // Idle passes requests through
    // DoAmo owns the SRAM for the write-back cycle
    typedef enum logic {
        Idle  = 1'b0,
        DoAmo = 1'b1
    } shim_state_e;

endpackage

// File: logic/req_fifo.sv
// Request FIFO between the host port and the AMO shim
// Host pushes with req/gnt, the shim pops the head through pop_i

`include "amo_defines.svh"

module req_fifo (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // Host side
    input  logic                       req_i,
    output logic                       gnt_o,
    input  logic [`AMO_ADDR_WIDTH-1:0] addr_i,
    input  amo_pkg::amo_op_e           amo_i,
    input  logic                       wen_i,    // 1 store, 0 load
    input  logic [63:0]                wdata_i,
    input  logic [7:0]                 be_i,
    // Shim side
    output logic                       valid_o,  // Head entry present
    input  logic                       pop_i,
    output logic [`AMO_ADDR_WIDTH-1:0] addr_o,
    output amo_pkg::amo_op_e           amo_o,
    output logic                       wen_o,
    output logic [63:0]                wdata_o,
    output logic [7:0]                 be_o
);

    localparam int unsigned Depth    = `AMO_FIFO_DEPTH;
    localparam int unsigned PtrWidth = $clog2(Depth);
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    logic [`AMO_ADDR_WIDTH-1:0] addr_mem  [Depth];
    amo_pkg::amo_op_e           amo_mem   [Depth];
    logic                       wen_mem   [Depth];
    logic [63:0]                wdata_mem [Depth];
    logic [7:0]                 be_mem    [Depth];

    logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic                full, push, pop;

    assign full    = (count_q == CntWidth'(Depth));
    assign valid_o = (count_q != '0);
    assign gnt_o   = !full || pop_i;  // Full FIFO still takes a push while popping
    assign push    = req_i && gnt_o;
    assign pop     = pop_i && valid_o;

    assign addr_o  = addr_mem[rd_ptr_q];
    assign amo_o   = amo_mem[rd_ptr_q];
    assign wen_o   = wen_mem[rd_ptr_q];
    assign wdata_o = wdata_mem[rd_ptr_q];
    assign be_o    = be_mem[rd_ptr_q];

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_mem[wr_ptr_q]  <= addr_i;
            amo_mem[wr_ptr_q]   <= amo_i;
            wen_mem[wr_ptr_q]   <= wen_i;
            wdata_mem[wr_ptr_q] <= wdata_i;
            be_mem[wr_ptr_q]    <= be_i;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: logic/amo_alu.sv
// Combinational 32-bit ALU for atomic memory operations
// Returns the value the shim writes back over the old half-word

module amo_alu (
    input  amo_pkg::amo_op_e op_i,
    input  logic [31:0]      mem_i,      // Old value from SRAM
    input  logic [31:0]      operand_i,  // Host operand or CAS compare value
    input  logic [31:0]      swap_i,     // CAS replacement value
    output logic [31:0]      result_o
);

    logic        signed_cmp;
    logic        subtract;
    logic [32:0] adder_a;
    logic [32:0] adder_b;
    logic [32:0] sum;
    logic        less;   // mem_i < operand_i
    logic        equal;

    // ------------------------------------------------------------------
    // Shared adder
    // ------------------------------------------------------------------

    // Signed compares need the sign bit copied into bit 32
    assign signed_cmp = (op_i == amo_pkg::AmoMax) || (op_i == amo_pkg::AmoMin);
    // Everything except Add compares by subtraction
    assign subtract   = (op_i != amo_pkg::AmoAdd);

    assign adder_a = {signed_cmp & mem_i[31], mem_i};
    assign adder_b = subtract ? ~{signed_cmp & operand_i[31], operand_i}
                              : {1'b0, operand_i};

    // Carry-in of one completes the two's complement negation
    assign sum = adder_a + adder_b + {32'b0, subtract};

    assign less  = sum[32];
    assign equal = (sum == '0);

    // ------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------

    always_comb begin
        result_o = mem_i;  // None leaves memory as it was
        unique case (op_i)
            amo_pkg::AmoSwap: result_o = operand_i;
            amo_pkg::AmoAdd:  result_o = sum[31:0];
            amo_pkg::AmoAnd:  result_o = mem_i & operand_i;
            amo_pkg::AmoOr:   result_o = mem_i | operand_i;
            amo_pkg::AmoXor:  result_o = mem_i ^ operand_i;
            amo_pkg::AmoMax,
            amo_pkg::AmoMaxu: begin
                result_o = less ? operand_i : mem_i;
            end
            amo_pkg::AmoMin,
            amo_pkg::AmoMinu: begin
                result_o = less ? mem_i : operand_i;
            end
            amo_pkg::AmoCas: begin
                // Swap only on a match
                result_o = equal ? swap_i : mem_i;
            end
            default: result_o = mem_i;
        endcase
    end

endmodule

// File: logic/amo_shim.sv
// Sequencer that runs loads, stores and atomics against the SRAM bank
// Plain accesses pass straight through, an AMO adds a write-back cycle

`include "amo_defines.svh"

module amo_shim (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // Request side
    input  logic                       in_req_i,
    output logic                       in_gnt_o,
    input  logic [`AMO_ADDR_WIDTH-1:0] in_addr_i,
    input  amo_pkg::amo_op_e           in_amo_i,
    input  logic                       in_wen_i,
    input  logic [63:0]                in_wdata_i,
    input  logic [7:0]                 in_be_i,
    // SRAM side
    output logic                       out_req_o,
    output logic [`AMO_ADDR_WIDTH-1:0] out_addr_o,
    output logic                       out_wen_o,
    output logic [63:0]                out_wdata_o,
    output logic [7:0]                 out_be_o,
    input  logic [63:0]                out_rdata_i,
    // Response
    output logic                       rvalid_o,
    output logic [63:0]                rdata_o
);

    amo_pkg::shim_state_e state_q, state_d;

    // AMO context captured with the read
    amo_pkg::amo_op_e           amo_op_q;
    logic [`AMO_ADDR_WIDTH-1:0] addr_q;
    logic [31:0]                operand_q;
    logic [31:0]                swap_q;
    logic                       upper_q;

    logic        start_amo;
    logic        read_grant;
    logic        rvalid_q;
    logic [31:0] old_word;
    logic [31:0] amo_result;

    assign start_amo  = (state_q == amo_pkg::Idle) && in_req_i
                     && (in_amo_i != amo_pkg::AmoNone);
    // An AMO is a read regardless of wen
    assign read_grant = in_req_i && in_gnt_o
                     && (!in_wen_i || (in_amo_i != amo_pkg::AmoNone));

    assign old_word = upper_q ? out_rdata_i[63:32] : out_rdata_i[31:0];

    amo_alu i_amo_alu (
        .op_i      (amo_op_q),
        .mem_i     (old_word),
        .operand_i (operand_q),
        .swap_i    (swap_q),
        .result_o  (amo_result)
    );

    // ------------------------------------------------------------------
    // SRAM port mux
    // ------------------------------------------------------------------

    always_comb begin
        in_gnt_o    = in_req_i;
        out_req_o   = in_req_i;
        out_addr_o  = in_addr_i;
        out_wen_o   = in_wen_i;
        out_wdata_o = in_wdata_i;
        out_be_o    = in_be_i;
        rdata_o     = out_rdata_i;
        state_d     = state_q;

        unique case (state_q)
            amo_pkg::Idle: begin
                if (start_amo) begin
                    out_wen_o = 1'b0;  // Read old value first
                    state_d   = amo_pkg::DoAmo;
                end
            end
            amo_pkg::DoAmo: begin
                // Write-back owns the port for this cycle
                in_gnt_o    = 1'b0;
                out_req_o   = 1'b1;
                out_addr_o  = addr_q;
                out_wen_o   = 1'b1;
                out_be_o    = upper_q ? 8'b1111_0000 : 8'b0000_1111;
                out_wdata_o = upper_q ? {amo_result, 32'b0} : {32'b0, amo_result};
                rdata_o     = upper_q ? {old_word, 32'b0} : {32'b0, old_word};
                state_d     = amo_pkg::Idle;
            end
            default: state_d = amo_pkg::Idle;
        endcase
    end

    assign rvalid_o = rvalid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= amo_pkg::Idle;
            rvalid_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            rvalid_q <= read_grant;  // Data is back one cycle later
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_amo) begin
            amo_op_q  <= in_amo_i;
            addr_q    <= in_addr_i;
            operand_q <= in_be_i[0] ? in_wdata_i[31:0] : in_wdata_i[63:32];
            swap_q    <= in_wdata_i[63:32];
            upper_q   <= in_be_i[4];
        end
    end

endmodule

// File: logic/sram_bank.sv
// Single-port 64-bit SRAM model with byte enables
// Read data is registered and shows up one cycle after the request

`include "amo_defines.svh"

module sram_bank (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       req_i,
    input  logic [`AMO_ADDR_WIDTH-1:0] addr_i,
    input  logic                       wen_i,    // 1 write, 0 read
    input  logic [63:0]                wdata_i,
    input  logic [7:0]                 be_i,
    output logic [63:0]                rdata_o
);

    localparam int unsigned Words    = `AMO_SRAM_WORDS;
    localparam int unsigned IdxWidth = $clog2(Words);

    logic [63:0]         mem_q [Words];
    logic [63:0]         rdata_q;
    logic [IdxWidth-1:0] idx;

    assign idx     = addr_i[IdxWidth+2:3];  // Word index above the byte offset
    assign rdata_o = rdata_q;

    // Byte-masked write
    always_ff @(posedge clk_i) begin
        if (req_i && wen_i) begin
            for (int b = 0; b < 8; b++) begin
                if (be_i[b]) mem_q[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
    end

    // Read register holds its value between reads
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q <= '0;
        end else if (req_i && !wen_i) begin
            rdata_q <= mem_q[idx];
        end
    end

endmodule

// File: logic/amo_mem_top.sv
// Top level of the AMO memory subsystem
// Host req/gnt port into the FIFO, shim and SRAM bank behind it

`include "amo_defines.svh"

module amo_mem_top (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       req_i,
    output logic                       gnt_o,
    input  logic [`AMO_ADDR_WIDTH-1:0] addr_i,
    input  amo_pkg::amo_op_e           amo_i,
    input  logic                       wen_i,
    input  logic [63:0]                wdata_i,
    input  logic [7:0]                 be_i,
    output logic                       rvalid_o,
    output logic [63:0]                rdata_o
);

    // FIFO head to shim
    logic                       in_req, in_gnt, in_wen;
    logic [`AMO_ADDR_WIDTH-1:0] in_addr;
    amo_pkg::amo_op_e           in_amo;
    logic [63:0]                in_wdata;
    logic [7:0]                 in_be;

    // Shim to SRAM
    logic                       out_req, out_wen;
    logic [`AMO_ADDR_WIDTH-1:0] out_addr;
    logic [63:0]                out_wdata, out_rdata;
    logic [7:0]                 out_be;

    req_fifo i_req_fifo (
        .clk_i, .rst_ni,
        .req_i, .gnt_o, .addr_i, .amo_i, .wen_i, .wdata_i, .be_i,
        .valid_o (in_req),   .pop_i   (in_gnt),
        .addr_o  (in_addr),  .amo_o   (in_amo),
        .wen_o   (in_wen),   .wdata_o (in_wdata),
        .be_o    (in_be)
    );

    amo_shim i_amo_shim (
        .clk_i, .rst_ni,
        .in_req_i   (in_req),   .in_gnt_o    (in_gnt),
        .in_addr_i  (in_addr),  .in_amo_i    (in_amo),
        .in_wen_i   (in_wen),   .in_wdata_i  (in_wdata),
        .in_be_i    (in_be),
        .out_req_o  (out_req),  .out_addr_o  (out_addr),
        .out_wen_o  (out_wen),  .out_wdata_o (out_wdata),
        .out_be_o   (out_be),   .out_rdata_i (out_rdata),
        .rvalid_o, .rdata_o
    );

    sram_bank i_sram_bank (
        .clk_i, .rst_ni,
        .req_i   (out_req),   .addr_i  (out_addr),
        .wen_i   (out_wen),   .wdata_i (out_wdata),
        .be_i    (out_be),    .rdata_o (out_rdata)
    );

endmodule

// File: verif/amo_mem_sva.sv
// Protocol checks on the AMO shim sequencer
// Bound into every amo_shim instance, failures show up as assertion errors

`include "amo_defines.svh"

module amo_mem_sva (
    input logic                       clk_i,
    input logic                       rst_ni,
    input amo_pkg::shim_state_e       state_i,
    input logic                       in_req_i,
    input logic                       in_gnt_i,
    input amo_pkg::amo_op_e           in_amo_i,
    input logic                       in_wen_i,
    input logic [`AMO_ADDR_WIDTH-1:0] in_addr_i,
    input logic                       out_req_i,
    input logic                       out_wen_i,
    input logic [`AMO_ADDR_WIDTH-1:0] out_addr_i,
    input logic                       rvalid_i
);
    timeunit 1ns;
    timeprecision 100ps;

    logic amo_taken;   // AMO accepted from the FIFO
    logic read_taken;  // Load or AMO accepted, both return data

    assign amo_taken  = in_req_i && in_gnt_i && (in_amo_i != amo_pkg::AmoNone);
    assign read_taken = in_req_i && in_gnt_i && (!in_wen_i || amo_taken);

    // First AMO cycle reads the old value, whatever wen says
    amo_reads_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
        amo_taken |-> out_req_i && !out_wen_i)
        else $error("AMO accepted without an SRAM read");

    doamo_writes: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(amo_taken) |-> state_i == amo_pkg::DoAmo && out_req_i && out_wen_i
                             && out_addr_i == $past(in_addr_i))
        else $error("DoAmo cycle without an SRAM write");

    doamo_no_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(amo_taken) |-> !in_gnt_i)
        else $error("Request granted during DoAmo");

    // Write-back takes exactly one cycle, then pass-through resumes
    doamo_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(amo_taken, 2) |-> state_i == amo_pkg::Idle && in_gnt_i == in_req_i)
        else $error("DoAmo lasted more than one cycle");

    // One response per granted read, one cycle later
    rvalid_follows_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i == $past(read_taken))
        else $error("rvalid_o does not follow a granted read");

endmodule

bind amo_shim amo_mem_sva sva_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .state_i    (state_q),
    .in_req_i   (in_req_i),
    .in_gnt_i   (in_gnt_o),
    .in_amo_i   (in_amo_i),
    .in_wen_i   (in_wen_i),
    .in_addr_i  (in_addr_i),
    .out_req_i  (out_req_o),
    .out_wen_i  (out_wen_o),
    .out_addr_i (out_addr_o),
    .rvalid_i   (rvalid_o)
);

// File: verif/amo_mem_tb.sv
// Testbench for the AMO memory subsystem
// Replays requests from verif/amo_tests.txt and checks responses in order

`include "amo_defines.svh"

module amo_mem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MaxTests = 64;

    logic                       clk_i;
    logic                       rst_ni;
    logic                       req_i;
    logic                       gnt_o;
    logic [`AMO_ADDR_WIDTH-1:0] addr_i;
    amo_pkg::amo_op_e           amo_i;
    logic                       wen_i;
    logic [63:0]                wdata_i;
    logic [7:0]                 be_i;
    logic                       rvalid_o;
    logic [63:0]                rdata_o;

    // Test table from the data file
    logic [8*16-1:0]            tag_tab   [MaxTests];
    logic [3:0]                 op_tab    [MaxTests];
    logic                       wen_tab   [MaxTests];
    logic [`AMO_ADDR_WIDTH-1:0] addr_tab  [MaxTests];
    logic [7:0]                 be_tab    [MaxTests];
    logic [63:0]                wdata_tab [MaxTests];
    logic [63:0]                exp_tab   [MaxTests];
    logic                       resp_tab  [MaxTests];  // Load or AMO
    int n_tests = 0;

    // Outstanding responses in request order
    logic [63:0]     exp_q     [$];
    logic [8*16-1:0] exp_tag_q [$];

    int n_pass = 0;
    int n_fail = 0;
    int n_stores = 0;
    int file_errors = 0;
    int cycle_cnt = 0;
    int cycle_limit = 0;

    amo_mem_top dut_i (.*);

    always #5 clk_i = ~clk_i;

    // ----------------------------------------------------------------------
    // Run limit
    // ----------------------------------------------------------------------

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d responses still missing",
                     cycle_cnt, exp_q.size());
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic load_tests();
        int              fd;
        int              n;
        string           line;
        logic [8*16-1:0] tag;
        logic [31:0]     op, wen, addr, be;
        logic [63:0]     wdata, exp_val;
        fd = $fopen("verif/amo_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test data file verif/amo_tests.txt");
            file_errors++;
            return;
        end
        while (!$feof(fd) && n_tests < MaxTests) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") continue;
            exp_val = '0;
            // The expected column is - for a store, so only six fields match
            n = $sscanf(line, "%s %h %h %h %h %h %h", tag, op, wen, addr, be, wdata, exp_val);
            if (n < 6) begin
                $display("Malformed line in test data file: %s", line);
                file_errors++;
                continue;
            end
            tag_tab[n_tests]   = tag;
            op_tab[n_tests]    = op[3:0];
            wen_tab[n_tests]   = wen[0];
            addr_tab[n_tests]  = addr[`AMO_ADDR_WIDTH-1:0];
            be_tab[n_tests]    = be[7:0];
            wdata_tab[n_tests] = wdata;
            exp_tab[n_tests]   = exp_val;
            resp_tab[n_tests]  = (op[3:0] != 4'h0) || !wen[0];
            if (resp_tab[n_tests] != (n == 7)) begin
                $display("Test %0s has an expected value that does not fit its request kind", tag);
                file_errors++;
            end
            n_tests++;
        end
        $fclose(fd);
    endtask

    // ----------------------------------------------------------------------
    // Driver and monitor
    // ----------------------------------------------------------------------

    task automatic drive_tests();
        for (int i = 0; i < n_tests; i++) begin
            if ($urandom % 8 == 0) begin  // Occasional idle gap
                req_i = 1'b0;
                @(negedge clk_i);
            end
            req_i   = 1'b1;
            addr_i  = addr_tab[i];
            amo_i   = amo_pkg::amo_op_e'(op_tab[i]);
            wen_i   = wen_tab[i];
            wdata_i = wdata_tab[i];
            be_i    = be_tab[i];
            // gnt_o only moves at a rising edge, so this value holds through the next one
            while (!gnt_o) @(negedge clk_i);  // Hold until granted
            if (resp_tab[i]) begin
                exp_q.push_back(exp_tab[i]);
                exp_tag_q.push_back(tag_tab[i]);
            end else begin
                $display("ok   %0s store granted at %0t", tag_tab[i], $time);
                n_stores++;
            end
            @(negedge clk_i);
        end
        req_i = 1'b0;
    endtask

    task automatic check_response();
        logic [63:0]     exp_val;
        logic [8*16-1:0] tag;
        if (exp_q.size() == 0) begin
            $display("Unexpected response at %0t with no request outstanding, rdata %h",
                     $time, rdata_o);
            n_fail++;
            return;
        end
        exp_val = exp_q.pop_front();
        tag     = exp_tag_q.pop_front();
        if (rdata_o !== exp_val) begin
            $display("FAILED at %0t: %0s rdata %h expected %h", $time, tag, rdata_o, exp_val);
            n_fail++;
        end else begin
            $display("ok   %0s rdata %h", tag, rdata_o);
            n_pass++;
        end
    endtask

    task automatic watch_responses();
        forever begin
            @(negedge clk_i);  // Response registers settle mid-cycle
            if (rvalid_o) check_response();
        end
    endtask

    initial begin
        clk_i   = 1'b0;
        rst_ni  = 1'b0;
        req_i   = 1'b0;
        addr_i  = '0;
        amo_i   = amo_pkg::AmoNone;
        wen_i   = 1'b0;
        wdata_i = '0;
        be_i    = '0;
        void'($urandom(32'h9593));
        load_tests();
        cycle_limit = 20 * n_tests + 100;
        repeat (8) @(negedge clk_i);
        // Empty FIFO grants, nothing to respond to yet
        if (gnt_o !== 1'b1 || rvalid_o !== 1'b0) begin
            $display("FAILED at %0t: after reset gnt_o %b rvalid_o %b, expected 1 and 0",
                     $time, gnt_o, rvalid_o);
            n_fail++;
        end
        rst_ni = 1'b1;
        fork
            watch_responses();
        join_none
        drive_tests();
        while (exp_q.size() != 0) @(posedge clk_i);
        repeat (5) @(posedge clk_i);  // Room for stray responses
        $display("Done: %0d responses ok, %0d stores, %0d failed, %0d data file errors",
                 n_pass, n_stores, n_fail, file_errors);
        if (n_tests > 0 && n_fail == 0 && file_errors == 0 && n_pass + n_stores == n_tests) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+logic
logic/amo_pkg.sv
logic/req_fifo.sv
logic/amo_alu.sv
logic/amo_shim.sv
logic/sram_bank.sv
logic/amo_mem_top.sv
verif/amo_mem_sva.sv
verif/amo_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the AMO memory testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module amo_mem_tb \
    -f flist.f \
    -o sim_amo_mem

# An assertion stop also ends the run, so the log decides the result
./obj_dir/sim_amo_mem > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log || ! grep -q "Simulation PASSED" sim.log; then
    echo "Run failed, see sim.log"
    exit 1
fi
echo "Run passed"

// File: verif/amo_tests.txt
# tag  op  wen  addr  be  wdata  expected_rdata   (all hex, op 0 is a plain access)
# expected_rdata is - for stores, which get no response
st_full   0 1 000 FF 1122334455667788 -
ld_full   0 0 000 FF 0000000000000000 1122334455667788
st_byte   0 1 000 05 AAAAAAAAAAAAAAAA -
ld_byte   0 0 000 FF 0000000000000000 1122334455AA77AA
st_arith  0 1 010 FF 123456789ABCDEF0 -
add_lo    2 0 010 0F 0000000000000010 000000009ABCDEF0
add_hi    2 0 010 F0 0000000100000000 1234567800000000
swap_lo   1 0 010 0F 00000000CAFEF00D 000000009ABCDF00
and_hi    3 0 010 F0 0F0F0F0F00000000 1234567900000000
or_lo     4 0 010 0F 0000000000000F00 00000000CAFEF00D
xor_hi    5 0 010 F0 FFFF000000000000 0204060900000000
ld_logic  0 0 010 FF 0000000000000000 FDFB0609CAFEFF0D
st_mm     0 1 020 FF FFFFFFFFFFFFFFFF -
max_lo    6 0 020 0F 0000000000000001 00000000FFFFFFFF
maxu_hi   7 0 020 F0 0000000100000000 FFFFFFFF00000000
ld_mm1    0 0 020 FF 0000000000000000 FFFFFFFF00000001
min_lo    8 0 020 0F 00000000FFFFFFFE 0000000000000001
minu_hi   9 0 020 F0 0000000200000000 FFFFFFFF00000000
ld_mm2    0 0 020 FF 0000000000000000 00000002FFFFFFFE
st_cas    0 1 030 FF 0000000000000064 -
cas_hit   A 0 030 0F 000000C800000064 0000000000000064
cas_miss  A 0 030 0F 000001F400000064 00000000000000C8
ld_cas    0 0 030 FF 0000000000000000 00000000000000C8
st_b      0 1 040 FF 0000000300000001 -
add_b1    2 0 040 0F 0000000000000001 0000000000000001
add_b2    2 0 040 0F 0000000000000001 0000000000000002
add_b3    2 0 040 F0 0000000500000000 0000000300000000
ld_b1     0 0 040 FF 0000000000000000 0000000800000003
ld_back   0 0 000 FF 0000000000000000 1122334455AA77AA
